//--- src/host_bus_pkg.sv
// register bus widths, request and response structs, fixed test word
package host_bus_pkg;

   localparam int DATA_WIDTH      = 32;
   localparam int REG_ADDR_WIDTH  = 32;
   localparam int TERM_ADDR_WIDTH = 16;

   // returned at odd register addresses, inverted at even ones
   localparam logic [DATA_WIDTH-1:0] PATTERN_WORD = 32'hBBAA9988;

   // request from the host, held until the access completes
   typedef struct packed {
      logic [TERM_ADDR_WIDTH-1:0] term_addr;
      logic [REG_ADDR_WIDTH-1:0]  reg_addr;
      logic                       read;
      logic                       write;
      logic [DATA_WIDTH-1:0]      wdata;
   } host_req_t;

   // response from a terminal
   typedef struct packed {
      logic [DATA_WIDTH-1:0] rdata;
      logic                  read_rdy;
      logic                  write_rdy;
   } host_resp_t;

endpackage

//--- src/mem_port_pkg.sv
// memory controller user port widths, command codes and port structs
package mem_port_pkg;

   localparam int MEM_ADDR_WIDTH = 30;
   localparam int MEM_DATA_WIDTH = 32;
   localparam int BURST_WIDTH    = 6;

   localparam logic [2:0] CMD_WRITE = 3'b000;
   localparam logic [2:0] CMD_READ  = 3'b001;

   typedef struct packed {
      logic                      cmd_en;
      logic [2:0]                instr;
      logic [BURST_WIDTH-1:0]    bl;
      logic [MEM_ADDR_WIDTH-1:0] byte_addr;
   } mem_cmd_t;

   // write mask is tied to zero inside the controller wrapper
   typedef struct packed {
      logic                      wr_en;
      logic [MEM_DATA_WIDTH-1:0] wr_data;
   } mem_wr_t;

   typedef struct packed {
      logic rd_en;
   } mem_rd_req_t;

   // flags and read data coming back from the port
   typedef struct packed {
      logic                      cmd_full;
      logic                      wr_full;
      logic                      rd_empty;
      logic [MEM_DATA_WIDTH-1:0] rd_data;
      logic                      wr_underrun;
      logic                      wr_error;
      logic                      rd_overflow;
      logic                      rd_error;
      logic                      calib_done;
   } mem_port_status_t;

endpackage

//--- src/term_router.sv
// terminal address decode, strobe steering, response mux and pattern terminal
`timescale 1ns/1ps

module term_router
   import host_bus_pkg::*;
#(
   parameter logic [TERM_ADDR_WIDTH-1:0] TERM_PATTERN   = 16'h0001,
   parameter logic [TERM_ADDR_WIDTH-1:0] TERM_DRAM      = 16'h0002,
   parameter logic [TERM_ADDR_WIDTH-1:0] TERM_DRAM_CTRL = 16'h0003
) (
   input  logic       ifclk,
   input  logic       reset,
   input  host_req_t  host_req,
   output host_resp_t host_resp,
   output host_req_t  ctrl_req,
   input  host_resp_t ctrl_resp,
   output host_req_t  dram_req,
   input  host_resp_t dram_resp,
   output host_req_t  user_req,
   input  host_resp_t user_resp
);

   localparam int SEL_PATTERN = 0;
   localparam int SEL_CTRL    = 1;
   localparam int SEL_DRAM    = 2;
   localparam int SEL_USER    = 3;

   logic [3:0] sel;
   host_resp_t pattern_resp;

   // copy of the request with strobes masked off unless selected
   function automatic host_req_t steer(input host_req_t req, input logic en);
      host_req_t gated;
      gated       = req;
      gated.read  = req.read & en;
      gated.write = req.write & en;
      return gated;
   endfunction

   // one-hot decode, anything unknown goes to the user terminal
   always_comb begin
      sel = '0;
      if (host_req.term_addr == TERM_PATTERN) begin
         sel[SEL_PATTERN] = 1'b1;
      end else if (host_req.term_addr == TERM_DRAM_CTRL) begin
         sel[SEL_CTRL] = 1'b1;
      end else if (host_req.term_addr == TERM_DRAM) begin
         sel[SEL_DRAM] = 1'b1;
      end else begin
         sel[SEL_USER] = 1'b1;
      end
   end

   assign ctrl_req = steer(host_req, sel[SEL_CTRL]);
   assign dram_req = steer(host_req, sel[SEL_DRAM]);
   assign user_req = steer(host_req, sel[SEL_USER]);

   // test terminal answers at once, writes go nowhere
   assign pattern_resp.rdata     = host_req.reg_addr[0] ? PATTERN_WORD : ~PATTERN_WORD;
   assign pattern_resp.read_rdy  = 1'b1;
   assign pattern_resp.write_rdy = 1'b1;

   always_comb begin
      if (sel[SEL_PATTERN]) begin
         host_resp = pattern_resp;
      end else if (sel[SEL_CTRL]) begin
         host_resp = ctrl_resp;
      end else if (sel[SEL_DRAM]) begin
         host_resp = dram_resp;
      end else begin
         host_resp = user_resp;
      end
   end

endmodule

//--- src/dram_status_terminal.sv
// memory status terminal with calib_done synchronizer and sticky port errors
`timescale 1ns/1ps

module dram_status_terminal
   import host_bus_pkg::*;
   import mem_port_pkg::*;
(
   input  logic             ifclk,
   input  logic             reset,
   input  host_req_t        req,
   output host_resp_t       resp,
   input  mem_port_status_t port_status
);

   logic [1:0]            calib_sync;
   logic [3:0]            sticky;
   logic [3:0]            err_flags;
   logic                  reg0_sel;
   logic                  clear;
   logic [DATA_WIDTH-1:0] status_word;

   assign err_flags = {port_status.rd_error, port_status.rd_overflow,
                       port_status.wr_error, port_status.wr_underrun};

   assign reg0_sel = (req.reg_addr == '0);

   // terminal is always ready, so a strobe means completion
   assign clear = req.write & reg0_sel;

   always_ff @(posedge ifclk) begin
      if (reset) begin
         calib_sync <= 2'b00;
      end else begin
         calib_sync <= {calib_sync[0], port_status.calib_done};
      end
   end

   // a flag raised in the same cycle as the clear still sticks
   always_ff @(posedge ifclk) begin
      if (reset) begin
         sticky <= 4'b0000;
      end else begin
         sticky <= (clear ? 4'b0000 : sticky) | err_flags;
      end
   end

   always_comb begin
      status_word      = '0;
      status_word[0]   = calib_sync[1];
      status_word[7:4] = sticky;
   end

   assign resp.rdata     = reg0_sel ? status_word : '0;
   assign resp.read_rdy  = 1'b1;
   assign resp.write_rdy = 1'b1;

endmodule

//--- src/dram_bridge.sv
// register bus to memory port bridge for single-word reads and writes
`timescale 1ns/1ps

module dram_bridge
   import host_bus_pkg::*;
   import mem_port_pkg::*;
(
   input  logic             ifclk,
   input  logic             reset,
   input  host_req_t        req,
   output host_resp_t       resp,
   output mem_cmd_t         mem_cmd,
   output mem_wr_t          mem_wr,
   output mem_rd_req_t      mem_rd,
   input  mem_port_status_t port_status
);

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_PUSH_WR,
      ST_ISSUE_WR,
      ST_ISSUE_RD,
      ST_WAIT_DATA,
      ST_HOLD_DATA
   } state_t;

   state_t                    state;
   state_t                    state_nxt;
   logic [MEM_ADDR_WIDTH-1:0] addr_q;
   logic [DATA_WIDTH-1:0]     wdata_q;
   logic [DATA_WIDTH-1:0]     rdata_q;
   logic                      wr_accept;
   logic                      rd_accept;
   logic                      rd_done;

   // write needs room for both the word and the command up front
   assign resp.write_rdy = (state == ST_IDLE) & req.write &
                           ~port_status.wr_full & ~port_status.cmd_full;
   assign resp.read_rdy  = (state == ST_HOLD_DATA);
   assign resp.rdata     = rdata_q;

   assign wr_accept = resp.write_rdy;
   assign rd_accept = (state == ST_IDLE) & req.read;
   assign rd_done   = resp.read_rdy & req.read;

   always_comb begin
      state_nxt = state;
      case (state)
         ST_IDLE: begin
            if (wr_accept) begin
               state_nxt = ST_PUSH_WR;
            end else if (rd_accept) begin
               state_nxt = ST_ISSUE_RD;
            end
         end
         ST_PUSH_WR: begin
            if (!port_status.wr_full) begin
               state_nxt = ST_ISSUE_WR;
            end
         end
         ST_ISSUE_WR: begin
            if (!port_status.cmd_full) begin
               state_nxt = ST_IDLE;
            end
         end
         ST_ISSUE_RD: begin
            if (!port_status.cmd_full) begin
               state_nxt = ST_WAIT_DATA;
            end
         end
         ST_WAIT_DATA: begin
            if (!port_status.rd_empty) begin
               state_nxt = ST_HOLD_DATA;
            end
         end
         ST_HOLD_DATA: begin
            if (rd_done) begin
               state_nxt = ST_IDLE;
            end
         end
         default: begin
            state_nxt = ST_IDLE;
         end
      endcase
   end

   always_ff @(posedge ifclk) begin
      if (reset) begin
         state <= ST_IDLE;
      end else begin
         state <= state_nxt;
      end
   end

   // register addresses are word addresses on the host side
   always_ff @(posedge ifclk) begin
      if (wr_accept || rd_accept) begin
         addr_q <= {req.reg_addr[MEM_ADDR_WIDTH-3:0], 2'b00};
      end
      if (wr_accept) begin
         wdata_q <= req.wdata;
      end
      if (state == ST_WAIT_DATA && !port_status.rd_empty) begin
         rdata_q <= port_status.rd_data;
      end
   end

   assign mem_cmd.cmd_en    = (state == ST_ISSUE_WR) | (state == ST_ISSUE_RD);
   assign mem_cmd.instr     = (state == ST_ISSUE_RD) ? CMD_READ : CMD_WRITE;
   assign mem_cmd.bl        = '0;
   assign mem_cmd.byte_addr = addr_q;

   assign mem_wr.wr_en   = (state == ST_PUSH_WR);
   assign mem_wr.wr_data = wdata_q;

   // word stays in the read FIFO until the host takes it
   assign mem_rd.rd_en = rd_done;

endmodule

//--- src/board_top.sv
// board top level joining terminal router, memory status terminal and memory bridge
`timescale 1ns/1ps

module board_top
   import host_bus_pkg::*;
   import mem_port_pkg::*;
#(
   parameter logic [TERM_ADDR_WIDTH-1:0] TERM_PATTERN   = 16'h0001,
   parameter logic [TERM_ADDR_WIDTH-1:0] TERM_DRAM      = 16'h0002,
   parameter logic [TERM_ADDR_WIDTH-1:0] TERM_DRAM_CTRL = 16'h0003
) (
   input  logic             ifclk,
   input  logic             reset,
   input  host_req_t        host_req,
   output host_resp_t       host_resp,
   output host_req_t        user_req,
   input  host_resp_t       user_resp,
   output mem_cmd_t         mem_cmd,
   output mem_wr_t          mem_wr,
   output mem_rd_req_t      mem_rd,
   input  mem_port_status_t port_status
);

   host_req_t  ctrl_req;
   host_resp_t ctrl_resp;
   host_req_t  dram_req;
   host_resp_t dram_resp;

   term_router #(
      .TERM_PATTERN   (TERM_PATTERN),
      .TERM_DRAM      (TERM_DRAM),
      .TERM_DRAM_CTRL (TERM_DRAM_CTRL)
   ) u_term_router (
      .ifclk     (ifclk),
      .reset     (reset),
      .host_req  (host_req),
      .host_resp (host_resp),
      .ctrl_req  (ctrl_req),
      .ctrl_resp (ctrl_resp),
      .dram_req  (dram_req),
      .dram_resp (dram_resp),
      .user_req  (user_req),
      .user_resp (user_resp)
   );

   dram_status_terminal u_dram_status (
      .ifclk       (ifclk),
      .reset       (reset),
      .req         (ctrl_req),
      .resp        (ctrl_resp),
      .port_status (port_status)
   );

   // only memory port 0 is used
   dram_bridge u_dram_bridge (
      .ifclk       (ifclk),
      .reset       (reset),
      .req         (dram_req),
      .resp        (dram_resp),
      .mem_cmd     (mem_cmd),
      .mem_wr      (mem_wr),
      .mem_rd      (mem_rd),
      .port_status (port_status)
   );

endmodule

//--- tests/mem_port_model.sv
// behavioral memory controller user port with word store and read latency
`timescale 1ns/1ps

module mem_port_model
   import mem_port_pkg::*;
#(
   parameter logic [31:0] SEED = 32'h0000_0001
) (
   input  logic             ifclk,
   input  logic             reset,
   input  mem_cmd_t         mem_cmd,
   input  mem_wr_t          mem_wr,
   input  mem_rd_req_t      mem_rd,
   input  logic             hold_cmd_full,
   input  logic [3:0]       err_flags,
   input  logic             calib_done,
   output mem_port_status_t port_status
);

   logic [MEM_DATA_WIDTH-1:0] mem [logic [MEM_ADDR_WIDTH-1:0]];
   logic                      cmd_seen;
   logic                      cmd_accept;
   logic [MEM_DATA_WIDTH-1:0] wr_word;
   logic                      rd_pending;
   logic [2:0]                rd_delay;
   logic [MEM_DATA_WIDTH-1:0] rd_hold;
   logic                      rd_valid;
   logic [MEM_DATA_WIDTH-1:0] rd_word;
   integer                    seed = SEED;
   integer                    rnd;

   // a new command waits one cycle before the port takes it
   assign port_status.cmd_full = hold_cmd_full | (mem_cmd.cmd_en & ~cmd_seen);
   assign cmd_accept           = mem_cmd.cmd_en & ~port_status.cmd_full;

   always @(posedge ifclk) begin
      if (reset) begin
         cmd_seen   <= 1'b0;
         rd_pending <= 1'b0;
         rd_delay   <= 3'd0;
         rd_valid   <= 1'b0;
      end else begin
         cmd_seen <= mem_cmd.cmd_en & ~cmd_accept;
         if (mem_wr.wr_en && !port_status.wr_full) begin
            wr_word <= mem_wr.wr_data;
         end
         if (cmd_accept && mem_cmd.instr == CMD_WRITE) begin
            mem[mem_cmd.byte_addr] = wr_word;
         end
         // read data shows up 1 to 4 cycles after the command
         if (cmd_accept && mem_cmd.instr == CMD_READ) begin
            rnd = $random(seed);
            rd_delay   <= 3'd1 + {1'b0, rnd[1:0]};
            rd_pending <= 1'b1;
            rd_hold    <= (mem.exists(mem_cmd.byte_addr) != 0) ? mem[mem_cmd.byte_addr] : '0;
         end else if (rd_pending) begin
            if (rd_delay == 3'd1) begin
               rd_pending <= 1'b0;
               rd_valid   <= 1'b1;
               rd_word    <= rd_hold;
            end else begin
               rd_delay <= rd_delay - 3'd1;
            end
         end
         if (mem_rd.rd_en && rd_valid) begin
            rd_valid <= 1'b0;
         end
      end
   end

   assign port_status.wr_full     = 1'b0;
   assign port_status.rd_empty    = ~rd_valid;
   assign port_status.rd_data     = rd_word;
   assign port_status.wr_underrun = err_flags[0];
   assign port_status.wr_error    = err_flags[1];
   assign port_status.rd_overflow = err_flags[2];
   assign port_status.rd_error    = err_flags[3];
   assign port_status.calib_done  = calib_done;

endmodule

//--- tests/board_top_tb.sv
// board_top testbench with clock, reset, stimulus table, checks, timeout and report
`timescale 1ns/1ps

module board_top_tb
   import host_bus_pkg::*;
   import mem_port_pkg::*;
();

   localparam int          CLK_PERIOD       = 10;
   localparam int          CYCLES_PER_ENTRY = 200;
   localparam int          HOLD_CYCLES      = 6;
   localparam logic [31:0] SEED_VALUE       = 32'hd3002ee4;
   localparam logic [15:0] TERM_PATTERN     = 16'h0001;
   localparam logic [15:0] TERM_DRAM        = 16'h0002;
   localparam logic [15:0] TERM_DRAM_CTRL   = 16'h0003;
   localparam logic [31:0] USER_MASK        = 32'h5A5A5A5A;

   typedef enum logic [2:0] {OP_READ, OP_WRITE, OP_CALIB, OP_ERR, OP_IDLE} op_t;

   typedef struct packed {
      op_t         op;
      logic [15:0] term;
      logic [31:0] addr;
      logic [31:0] data;
      logic [31:0] exp_data;
      logic        bp;
   } entry_t;

   logic             ifclk;
   logic             reset;
   host_req_t        host_req;
   host_resp_t       host_resp;
   host_req_t        user_req;
   host_resp_t       user_resp;
   mem_cmd_t         mem_cmd;
   mem_wr_t          mem_wr;
   mem_rd_req_t      mem_rd;
   mem_port_status_t port_status;
   logic             hold_cmd_full;
   logic [3:0]       err_flags;
   logic             calib_done;
   mem_cmd_t         last_cmd;
   entry_t           table_q[$];
   integer           seed = SEED_VALUE;
   int               cmd_count = 0;
   int               push_count = 0;
   int               cycle_count = 0;
   int               timeout_limit = 0;
   int               error_count = 0;
   int               failed_tests = 0;

   board_top #(
      .TERM_PATTERN   (TERM_PATTERN),
      .TERM_DRAM      (TERM_DRAM),
      .TERM_DRAM_CTRL (TERM_DRAM_CTRL)
   ) UUT (
      .ifclk       (ifclk),
      .reset       (reset),
      .host_req    (host_req),
      .host_resp   (host_resp),
      .user_req    (user_req),
      .user_resp   (user_resp),
      .mem_cmd     (mem_cmd),
      .mem_wr      (mem_wr),
      .mem_rd      (mem_rd),
      .port_status (port_status)
   );

   mem_port_model #(.SEED(SEED_VALUE)) u_mem_port (
      .ifclk         (ifclk),
      .reset         (reset),
      .mem_cmd       (mem_cmd),
      .mem_wr        (mem_wr),
      .mem_rd        (mem_rd),
      .hold_cmd_full (hold_cmd_full),
      .err_flags     (err_flags),
      .calib_done    (calib_done),
      .port_status   (port_status)
   );

   // user terminal stand-in, always ready
   assign user_resp.rdata     = user_req.reg_addr ^ USER_MASK;
   assign user_resp.read_rdy  = 1'b1;
   assign user_resp.write_rdy = 1'b1;

   initial begin
      ifclk = 1'b0;
      forever #(CLK_PERIOD / 2) ifclk = ~ifclk;
   end

   // counts commands and word pushes taken by the port
   always @(posedge ifclk) begin
      if (!reset) begin
         if (mem_cmd.cmd_en && !port_status.cmd_full) begin
            cmd_count <= cmd_count + 1;
            last_cmd  <= mem_cmd;
         end
         if (mem_wr.wr_en && !port_status.wr_full) begin
            push_count <= push_count + 1;
         end
      end
   end

   always @(posedge ifclk) begin
      cycle_count <= cycle_count + 1;
      if (timeout_limit > 0 && cycle_count >= timeout_limit) begin
         $display("timeout: the run did not finish within %0d cycles", timeout_limit);
         $display("Errors found");
         $finish;
      end
   end

   task automatic report_mismatch(input int idx, input string sig,
                                  input logic [31:0] got, input logic [31:0] exp);
      $display("** Error entry %0d: %s = %h, expected %h", idx, sig, got, exp);
      error_count++;
   endtask

   task automatic report_problem(input int idx, input string what);
      $display("entry %0d: %s", idx, what);
      error_count++;
   endtask

   task automatic add_entry(input op_t op, input logic [15:0] term, input logic [31:0] addr,
                            input logic [31:0] data, input logic [31:0] exp_data,
                            input logic bp);
      table_q.push_back('{op, term, addr, data, exp_data, bp});
   endtask

   task automatic build_table();
      logic [31:0] d0, d1, d2, d3, d4, d5;
      d0 = $random(seed);
      d1 = $random(seed);
      d2 = $random(seed);
      d3 = $random(seed);
      d4 = $random(seed);
      d5 = $random(seed);
      add_entry(OP_READ, TERM_PATTERN, 32'h1, 32'h0, PATTERN_WORD, 1'b0);
      add_entry(OP_READ, TERM_PATTERN, 32'h2, 32'h0, ~PATTERN_WORD, 1'b0);
      add_entry(OP_READ, TERM_PATTERN, 32'h7, 32'h0, PATTERN_WORD, 1'b0);
      add_entry(OP_WRITE, TERM_PATTERN, 32'h3, d4, 32'h0, 1'b0);
      add_entry(OP_READ, TERM_PATTERN, 32'h3, 32'h0, PATTERN_WORD, 1'b0);
      add_entry(OP_READ, TERM_DRAM_CTRL, 32'h0, 32'h0, 32'h0, 1'b0);
      add_entry(OP_WRITE, TERM_DRAM, 32'h10, d0, 32'h0, 1'b0);
      add_entry(OP_WRITE, TERM_DRAM, 32'h2A5, d1, 32'h0, 1'b0);
      add_entry(OP_WRITE, TERM_DRAM, 32'h3FFF, d2, 32'h0, 1'b0);
      add_entry(OP_READ, TERM_DRAM, 32'h10, 32'h0, d0, 1'b0);
      add_entry(OP_READ, TERM_DRAM, 32'h3FFF, 32'h0, d2, 1'b0);
      add_entry(OP_READ, TERM_DRAM, 32'h2A5, 32'h0, d1, 1'b0);
      add_entry(OP_WRITE, TERM_DRAM, 32'h80, d3, 32'h0, 1'b1);
      add_entry(OP_READ, TERM_DRAM, 32'h80, 32'h0, d3, 1'b0);
      add_entry(OP_WRITE, TERM_DRAM, 32'h10, d5, 32'h0, 1'b0);
      add_entry(OP_READ, TERM_DRAM, 32'h10, 32'h0, d5, 1'b0);
      // status word: calib_done in bit 0, wr_error sticky in bit 5
      add_entry(OP_CALIB, TERM_DRAM_CTRL, 32'h0, 32'h1, 32'h0, 1'b0);
      add_entry(OP_IDLE, TERM_DRAM_CTRL, 32'h0, 32'h3, 32'h0, 1'b0);
      add_entry(OP_READ, TERM_DRAM_CTRL, 32'h0, 32'h0, 32'h0000_0001, 1'b0);
      add_entry(OP_ERR, TERM_DRAM_CTRL, 32'h0, 32'h2, 32'h0, 1'b0);
      add_entry(OP_IDLE, TERM_DRAM_CTRL, 32'h0, 32'h2, 32'h0, 1'b0);
      add_entry(OP_READ, TERM_DRAM_CTRL, 32'h0, 32'h0, 32'h0000_0021, 1'b0);
      add_entry(OP_READ, TERM_DRAM_CTRL, 32'h0, 32'h0, 32'h0000_0021, 1'b0);
      add_entry(OP_READ, TERM_DRAM_CTRL, 32'h5, 32'h0, 32'h0, 1'b0);
      add_entry(OP_WRITE, TERM_DRAM_CTRL, 32'h0, 32'h0, 32'h0, 1'b0);
      add_entry(OP_READ, TERM_DRAM_CTRL, 32'h0, 32'h0, 32'h0000_0001, 1'b0);
      add_entry(OP_READ, 16'h0042, 32'h1234, 32'h0, 32'h1234 ^ USER_MASK, 1'b0);
      add_entry(OP_WRITE, 16'h7777, 32'h8, d4, 32'h0, 1'b0);
      add_entry(OP_READ, 16'hFFFF, 32'hCAFE0001, 32'h0, 32'hCAFE0001 ^ USER_MASK, 1'b0);
   endtask

   // starts and ends on a falling edge; samples 1 ns after it
   task automatic host_access(input logic is_write, input logic [15:0] term,
                              input logic [31:0] addr, input logic [31:0] data,
                              output logic [31:0] rdata, output host_req_t user_seen);
      logic ready;
      host_req.term_addr = term;
      host_req.reg_addr  = addr;
      host_req.wdata     = data;
      host_req.read      = ~is_write;
      host_req.write     = is_write;
      ready = 1'b0;
      while (!ready) begin
         #1;
         ready     = is_write ? host_resp.write_rdy : host_resp.read_rdy;
         rdata     = host_resp.rdata;
         user_seen = user_req;
         @(negedge ifclk);
      end
      host_req.read  = 1'b0;
      host_req.write = 1'b0;
   endtask

   task automatic check_dram_path(input int idx, input entry_t e, input int cmds_before,
                                  input int pushes_before);
      logic [29:0] exp_baddr;
      logic [31:0] rdata;
      host_req_t   user_seen;
      int          exp_cmds;
      exp_baddr = e.addr[29:0] << 2;
      exp_cmds  = 1;
      if (e.op == OP_WRITE && e.bp) begin
         exp_cmds      = 2;
         hold_cmd_full = 1'b1;
         @(negedge ifclk);
         // a second write to the same word waits behind the stalled command
         host_req.write = 1'b1;
         repeat (HOLD_CYCLES) begin
            #1;
            if (mem_cmd.cmd_en !== 1'b1)
               report_mismatch(idx, "mem_cmd.cmd_en", 32'(mem_cmd.cmd_en), 32'h1);
            if (host_resp.write_rdy !== 1'b0)
               report_mismatch(idx, "host_resp.write_rdy", 32'(host_resp.write_rdy), 32'h0);
            @(negedge ifclk);
         end
         hold_cmd_full = 1'b0;
         if (cmd_count != cmds_before)
            report_problem(idx, "write command was taken while cmd_full was high");
         host_access(1'b1, e.term, e.addr, e.data, rdata, user_seen);
      end
      while (cmd_count < cmds_before + exp_cmds) begin
         @(negedge ifclk);
      end
      // one more cycle shows a command held for too long
      @(negedge ifclk);
      if (cmd_count != cmds_before + exp_cmds)
         report_mismatch(idx, "cmd_count", cmd_count, cmds_before + exp_cmds);
      if (last_cmd.byte_addr !== exp_baddr)
         report_mismatch(idx, "mem_cmd.byte_addr", 32'(last_cmd.byte_addr), 32'(exp_baddr));
      if (last_cmd.bl !== '0)
         report_mismatch(idx, "mem_cmd.bl", 32'(last_cmd.bl), 32'h0);
      if (last_cmd.instr !== ((e.op == OP_WRITE) ? CMD_WRITE : CMD_READ))
         report_mismatch(idx, "mem_cmd.instr", 32'(last_cmd.instr),
                         32'((e.op == OP_WRITE) ? CMD_WRITE : CMD_READ));
      if (e.op == OP_WRITE && push_count != pushes_before + exp_cmds)
         report_mismatch(idx, "push_count", push_count, pushes_before + exp_cmds);
   endtask

   task automatic run_entry(input int idx);
      entry_t      e;
      int          cmds_before;
      int          pushes_before;
      int          errors_before;
      logic [31:0] rdata;
      host_req_t   user_seen;
      logic        user_strobe;
      logic        is_user;
      e = table_q[idx];
      cmds_before   = cmd_count;
      pushes_before = push_count;
      errors_before = error_count;
      is_user = (e.term != TERM_PATTERN) && (e.term != TERM_DRAM) && (e.term != TERM_DRAM_CTRL);
      case (e.op)
         OP_CALIB: begin
            calib_done = e.data[0];
            @(negedge ifclk);
         end
         OP_ERR: begin
            err_flags = e.data[3:0];
            @(negedge ifclk);
            err_flags = 4'b0000;
         end
         OP_IDLE: begin
            repeat (e.data) @(negedge ifclk);
         end
         default: begin
            host_access(e.op == OP_WRITE, e.term, e.addr, e.data, rdata, user_seen);
            user_strobe = (e.op == OP_WRITE) ? user_seen.write : user_seen.read;
            if (e.op == OP_READ && rdata !== e.exp_data)
               report_mismatch(idx, "host_resp.rdata", rdata, e.exp_data);
            if (user_strobe !== is_user)
               report_mismatch(idx, "user_req strobe", 32'(user_strobe), 32'(is_user));
            if (is_user) begin
               if (user_seen.term_addr !== e.term)
                  report_mismatch(idx, "user_req.term_addr", 32'(user_seen.term_addr),
                                  32'(e.term));
               if (user_seen.reg_addr !== e.addr)
                  report_mismatch(idx, "user_req.reg_addr", user_seen.reg_addr, e.addr);
               if (e.op == OP_WRITE && user_seen.wdata !== e.data)
                  report_mismatch(idx, "user_req.wdata", user_seen.wdata, e.data);
            end
            if (e.term == TERM_DRAM) begin
               check_dram_path(idx, e, cmds_before, pushes_before);
            end else begin
               // a strobe leaking into the bridge reaches the port within three cycles
               repeat (3) @(negedge ifclk);
               if (cmd_count != cmds_before)
                  report_problem(idx, "memory port received a command for another terminal");
            end
         end
      endcase
      if (error_count == errors_before) begin
         $display("entry %0d %s term %h reg %h: ok", idx, e.op.name(), e.term, e.addr);
      end else begin
         failed_tests++;
         $display("entry %0d %s term %h reg %h: failed", idx, e.op.name(), e.term, e.addr);
      end
   endtask

   initial begin
      reset         = 1'b1;
      host_req      = '0;
      hold_cmd_full = 1'b0;
      err_flags     = 4'b0000;
      calib_done    = 1'b0;
      build_table();
      timeout_limit = CYCLES_PER_ENTRY * table_q.size();
      repeat (3) @(posedge ifclk);
      @(negedge ifclk);
      reset = 1'b0;
      for (int i = 0; i < table_q.size(); i++) begin
         run_entry(i);
      end
      $display("%0d tests, %0d passed, %0d failed, %0d errors", table_q.size(),
               table_q.size() - failed_tests, failed_tests, error_count);
      if (error_count == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

endmodule

//--- sim.f
src/host_bus_pkg.sv
src/mem_port_pkg.sv
src/term_router.sv
src/dram_status_terminal.sv
src/dram_bridge.sv
src/board_top.sv
tests/mem_port_model.sv
tests/board_top_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= board_top_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= No errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
